// ==== project.f ====
+incdir+.
aluFlagPkg.sv
aluOpPkg.sv
aluDecode.sv
aluAdder.sv
condEval.sv
aluLogicMove.sv
aluRetire.sv
aluTop.sv
aluTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --timescale 1ns/1ps \
  --top-module aluTb -f project.f -o aluSim

./obj_dir/aluSim > sim.log 2>&1
cat sim.log

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
exit 0

// ==== aluTb.sv ====
// ALU stage testbench: random and directed ops checked against a reference model
`timescale 1ns/1ps
`include "alu_macros.svh"

module aluTb;

  localparam int timeoutCycles = 3000; // ~1950 ops plus reset and drains

  typedef struct packed {
    aluOpPkg::aluOp_t op;
    aluOpPkg::dataWord_t result;
    aluFlagPkg::retData_t retData;
    logic retEn;
    int issueCycle;
  } expect_t;

  logic clk;
  logic rst;
  aluOpPkg::aluOp_t op;
  aluOpPkg::dataWord_t val1;
  aluOpPkg::dataWord_t val2;
  aluFlagPkg::aluFlags_t condFlags;
  logic dataEn;
  logic thread;
  logic except;
  logic exceptThread;
  logic error;
  aluOpPkg::dataWord_t result;
  aluFlagPkg::retData_t retData;
  logic retEn;

  integer seed = 32'hf7c9;
  int cycles = 0;
  int passCount = 0;
  int failCount = 0;
  int testFails;
  int testChecks;
  logic prevExc = 1'b0;
  logic prevExcThr = 1'b0;
  expect_t expQ[$];

  aluTop u_aluTop (
    .clk          (clk),
    .rst          (rst),
    .op           (op),
    .val1         (val1),
    .val2         (val2),
    .condFlags    (condFlags),
    .dataEn       (dataEn),
    .thread       (thread),
    .except       (except),
    .exceptThread (exceptThread),
    .error        (error),
    .result       (result),
    .retData      (retData),
    .retEn        (retEn)
  );

  always #2 clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
  end

  function automatic logic condTaken(input aluFlagPkg::aluFlags_t f,
                                     input aluFlagPkg::condCode_e cc);
    logic [3:0] code;
    logic base;
    code = cc;
    case (code[3:1])
      3'd0: base = f.z;
      3'd1: base = f.s;
      3'd2: base = f.c;
      3'd3: base = f.c | f.z;
      3'd4: base = f.s ^ f.o;
      3'd5: base = (f.s ^ f.o) | f.z;
      3'd6: base = f.o;
      default: base = f.p;
    endcase
    return base ^ code[0]; // odd code inverts
  endfunction

  function automatic expect_t refAlu(input aluOpPkg::aluOp_t o,
                                     input aluOpPkg::dataWord_t v1,
                                     input aluOpPkg::dataWord_t v2,
                                     input aluFlagPkg::aluFlags_t cf,
                                     input logic en,
                                     input logic err);
    expect_t e;
    aluOpPkg::dataWord_t mask;
    aluOpPkg::dataWord_t signMask;
    aluOpPkg::dataWord_t a;
    aluOpPkg::dataWord_t b;
    aluOpPkg::dataWord_t r;
    aluOpPkg::dataWord_t low;
    logic [64:0] wide;
    logic [4:0] nib;
    aluFlagPkg::aluFlags_t f;
    logic sa;
    logic sb;
    logic flagOp;
    int bits;
    e = '0;
    e.op = o;
    bits = 8 << o.width;
    mask = (bits == 64) ? '1 : ((64'd1 << bits) - 64'd1);
    signMask = 64'd1 << (bits - 1);
    a = v1 & mask;
    b = v2 & mask;
    f = '0;
    r = '0;
    flagOp = 1'b1;
    case (o.opcode)
      aluOpPkg::add:
      begin
        wide = {1'b0, a} + {1'b0, b};
        nib = {1'b0, a[3:0]} + {1'b0, b[3:0]};
        r = wide[63:0] & mask;
        f.c = (wide >> bits) != '0;
        f.a = nib[4];
      end
      aluOpPkg::sub:
      begin
        r = (a - b) & mask;
        f.c = a < b; // borrow
        f.a = a[3:0] < b[3:0];
      end
      aluOpPkg::andOp:  r = a & b;
      aluOpPkg::andNot: r = a & ~b & mask;
      aluOpPkg::orOp:   r = a | b;
      aluOpPkg::xorOp:  r = a ^ b;
      aluOpPkg::xnorOp: r = ~(a ^ b) & mask;
      default:          flagOp = 1'b0;
    endcase
    sa = (a & signMask) != '0;
    sb = (b & signMask) != '0;
    f.s = (r & signMask) != '0;
    if (o.opcode == aluOpPkg::add)
      f.o = (sa == sb) && (f.s != sa);
    else if (o.opcode == aluOpPkg::sub)
      f.o = (sa != sb) && (f.s != sa);
    f.z = (r == '0);
    f.p = ~^r[7:0];
    low = (o.opcode == aluOpPkg::mov) ? (v2 & mask) : r;
    // 32 zero-extends, 8/16 keep val1 above the width
    e.result = (bits == 32) ? low : ((v1 & ~mask) | low);
    case (o.opcode)
      aluOpPkg::zext: e.result = v2 & mask;
      aluOpPkg::sext: e.result = ((v2 & signMask) != '0) ? (v2 | ~mask) : (v2 & mask);
      aluOpPkg::cmov: e.result = condTaken(cf, o.cond) ? v2 : v1;
      aluOpPkg::cset: e.result = {{(`ALU_DATA_W-1){1'b0}}, condTaken(cf, o.cond)};
      default: ;
    endcase
    e.retData.setsFlags = o.setFlags & flagOp & en & ~err;
    e.retData.flags = e.retData.setsFlags ? f : '0;
    e.retData.status = err ? aluFlagPkg::fault : (en ? aluFlagPkg::done : aluFlagPkg::idle);
    return e;
  endfunction

  task automatic checkResult(input aluOpPkg::dataWord_t got, input aluOpPkg::dataWord_t exp,
                             input string msg);
    if (got !== exp)
    begin
      failCount++;
      $display("mismatch at %0t: %s result got %h expected %h", $time, msg, got, exp);
    end
    else
      passCount++;
  endtask

  task automatic checkRetData(input aluFlagPkg::retData_t got, input aluFlagPkg::retData_t exp,
                              input string msg);
    if (got !== exp)
    begin
      failCount++;
      $display("mismatch at %0t: %s retData got %h expected %h", $time, msg, got, exp);
    end
    else
      passCount++;
  endtask

  task automatic checkRetEn(input logic got, input logic exp, input string msg);
    if (got !== exp)
    begin
      failCount++;
      $display("mismatch at %0t: %s retEn got %b expected %b", $time, msg, got, exp);
    end
    else
      passCount++;
  endtask

  // each entry retires one edge after its issue
  initial
  begin : compare
    expect_t e;
    string msg;
    forever
    begin
      @(posedge clk);
      #2;
      if (expQ.size() != 0 && expQ[0].issueCycle < cycles)
      begin
        e = expQ.pop_front();
        msg = $sformatf("cycle %0d opcode %0d width %0d", e.issueCycle, e.op.opcode, e.op.width);
        checkResult(result, e.result, msg);
        checkRetData(retData, e.retData, msg);
        checkRetEn(retEn, e.retEn, msg);
      end
    end
  end

  initial
  begin : watchdog
    while (cycles < timeoutCycles)
      @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", timeoutCycles);
    $display("Testbench failed");
    $finish;
  end

  task automatic issue(input aluOpPkg::aluOp_t o, input aluOpPkg::dataWord_t v1,
                       input aluOpPkg::dataWord_t v2, input aluFlagPkg::aluFlags_t cf,
                       input logic en, input logic err, input logic thr,
                       input logic exc, input logic excThr);
    expect_t e;
    logic inhibit;
    @(posedge clk);
    #1;
    op = o;
    val1 = v1;
    val2 = v2;
    condFlags = cf;
    dataEn = en;
    error = err;
    thread = thr;
    except = exc;
    exceptThread = excThr;
    e = refAlu(o, v1, v2, cf, en, err);
    inhibit = (exc && excThr == thr) || (prevExc && prevExcThr == thr);
    e.retEn = en & ~inhibit;
    e.issueCycle = cycles;
    prevExc = exc;
    prevExcThr = excThr;
    expQ.push_back(e);
  endtask

  task automatic randOperand(output aluOpPkg::dataWord_t w);
    logic [31:0] sel;
    aluOpPkg::dataWord_t raw;
    sel = $random(seed);
    raw = {$random(seed), $random(seed)};
    case (sel[3:0])
      4'd0: w = '0;
      4'd1: w = '1;
      4'd2: w = 64'h8000_0000_0000_0000;
      4'd3: w = 64'h7fff_ffff_ffff_ffff;
      4'd4: w = {raw[63:32], 32'h8000_0000};
      4'd5: w = {raw[63:16], 16'h7fff};
      4'd6: w = {raw[63:16], 16'h8000};
      4'd7: w = {raw[63:8], 8'h80};
      4'd8: w = {raw[63:8], 8'h7f};
      default: w = raw;
    endcase
  endtask

  task automatic randOp(input aluOpPkg::opcode_e oc, output aluOpPkg::aluOp_t o);
    logic [31:0] rnd;
    rnd = $random(seed);
    o.opcode = oc;
    o.width = aluOpPkg::opWidth_e'(rnd[1:0]);
    o.cond = aluFlagPkg::condCode_e'(rnd[5:2]);
    o.setFlags = rnd[6];
  endtask

  task automatic randAnyOp(output aluOpPkg::aluOp_t o);
    logic [31:0] rnd;
    rnd = $random(seed);
    randOp(aluOpPkg::opcode_e'(4'(rnd[7:0] % 8'd12)), o);
  endtask

  task automatic issueWith(input aluOpPkg::aluOp_t o, input logic en, input logic err,
                           input logic thr, input logic exc, input logic excThr);
    aluOpPkg::dataWord_t v1;
    aluOpPkg::dataWord_t v2;
    logic [31:0] rnd;
    randOperand(v1);
    randOperand(v2);
    rnd = $random(seed);
    issue(o, v1, v2, aluFlagPkg::aluFlags_t'(rnd[5:0]), en, err, thr, exc, excThr);
  endtask

  // idle the inputs and let the last entry retire
  task automatic drain;
    @(posedge clk);
    #1;
    dataEn = 1'b0;
    error = 1'b0;
    except = 1'b0;
    prevExc = 1'b0;
    while (expQ.size() != 0)
    begin
      @(posedge clk);
      #3;
    end
  endtask

  task automatic startTest;
    testFails = failCount;
    testChecks = passCount + failCount;
  endtask

  task automatic finishTest(input string name);
    drain();
    $display("test %s: %0d checks, %0d errors", name,
             passCount + failCount - testChecks, failCount - testFails);
  endtask

  initial
  begin : main
    aluOpPkg::aluOp_t o;
    logic [31:0] rnd;
    clk = 1'b0;
    rst = 1'b1;
    op = '0;
    val1 = '1;
    val2 = '1;
    condFlags = '0;
    dataEn = 1'b1; // live op held across reset
    thread = 1'b0;
    except = 1'b0;
    exceptThread = 1'b0;
    error = 1'b0;

    startTest();
    repeat (4)
    begin
      @(posedge clk);
      #1;
      checkRetEn(retEn, 1'b0, "in reset");
      checkRetData(retData, '0, "in reset");
      checkResult(result, '0, "in reset");
    end
    rst = 1'b0;
    dataEn = 1'b0;
    #1;
    checkRetEn(retEn, 1'b0, "after reset");
    checkRetData(retData, '0, "after reset");
    $display("test reset: %0d checks, %0d errors", passCount + failCount - testChecks,
             failCount - testFails);

    startTest();
    repeat (600)
    begin
      rnd = $random(seed);
      randOp(rnd[0] ? aluOpPkg::sub : aluOpPkg::add, o);
      issueWith(o, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    end
    finishTest("arith");

    startTest();
    repeat (300)
    begin
      rnd = $random(seed);
      randOp(aluOpPkg::opcode_e'(4'(rnd[7:0] % 8'd5 + 8'd2)), o); // andOp to xnorOp
      issueWith(o, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    end
    finishTest("logic");

    startTest();
    for (int w = 0; w < 4; w++)
    begin
      repeat (30)
      begin
        rnd = $random(seed);
        randOp(aluOpPkg::opcode_e'(4'(rnd[7:0] % 8'd3 + 8'd7)), o); // mov, zext, sext
        o.width = aluOpPkg::opWidth_e'(w[1:0]);
        issueWith(o, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
      end
    end
    finishTest("move");

    startTest();
    for (int c = 0; c < 16; c++)
    begin
      repeat (16)
      begin
        rnd = $random(seed);
        randOp(rnd[0] ? aluOpPkg::cset : aluOpPkg::cmov, o);
        o.cond = aluFlagPkg::condCode_e'(c[3:0]);
        issueWith(o, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
      end
    end
    finishTest("cond");

    startTest();
    randAnyOp(o);
    issueWith(o, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0); // same thread, same cycle
    issueWith(o, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0); // same thread, one cycle back
    issueWith(o, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0); // other thread
    issueWith(o, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    issueWith(o, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
    repeat (80)
    begin
      rnd = $random(seed);
      randAnyOp(o);
      issueWith(o, rnd[0], rnd[3:1] == 3'd0, rnd[4], rnd[6:5] == 2'd0, rnd[7]);
    end
    finishTest("retire");

    startTest();
    repeat (600)
    begin
      rnd = $random(seed);
      randAnyOp(o);
      issueWith(o, 1'b1, 1'b0, rnd[0], 1'b0, 1'b0);
    end
    finishTest("stream");

    $display("checks passed %0d, failed %0d", passCount, failCount);
    if (failCount == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

// ==== aluTop.sv ====
// ALU stage top level: decode, adder, logic/move unit and retire register
`timescale 1ns/1ps

module aluTop (
  input  logic clk,
  input  logic rst,
  input  aluOpPkg::aluOp_t op,
  input  aluOpPkg::dataWord_t val1,
  input  aluOpPkg::dataWord_t val2,
  input  aluFlagPkg::aluFlags_t condFlags,
  input  logic dataEn,
  input  logic thread,
  input  logic except,
  input  logic exceptThread,
  input  logic error,
  output aluOpPkg::dataWord_t result,
  output aluFlagPkg::retData_t retData,
  output logic retEn
);

  aluOpPkg::opClass_t opClass;
  aluOpPkg::dataWord_t arithResult;
  aluOpPkg::dataWord_t lmResult;
  aluFlagPkg::arithFlags_t arithFlags;

  aluDecode uDecode (
    .op      (op),
    .opClass (opClass)
  );

  aluAdder uAdder (
    .op          (op),
    .opClass     (opClass),
    .val1        (val1),
    .val2        (val2),
    .arithResult (arithResult),
    .arithFlags  (arithFlags)
  );

  aluLogicMove uLogicMove (
    .op        (op),
    .opClass   (opClass),
    .val1      (val1),
    .val2      (val2),
    .condFlags (condFlags),
    .lmResult  (lmResult)
  );

  aluRetire uRetire (
    .clk          (clk),
    .rst          (rst),
    .opClass      (opClass),
    .width        (op.width),
    .arithResult  (arithResult),
    .lmResult     (lmResult),
    .arithFlags   (arithFlags),
    .dataEn       (dataEn),
    .error        (error),
    .thread       (thread),
    .except       (except),
    .exceptThread (exceptThread),
    .result       (result),
    .retData      (retData),
    .retEn        (retEn)
  );

endmodule

// ==== aluRetire.sv ====
// ALU retire stage: registers the result, builds flags, status and retire enable
`timescale 1ns/1ps
`include "alu_macros.svh"

module aluRetire (
  input  logic clk,
  input  logic rst,
  input  aluOpPkg::opClass_t opClass,
  input  aluOpPkg::opWidth_e width,
  input  aluOpPkg::dataWord_t arithResult,
  input  aluOpPkg::dataWord_t lmResult,
  input  aluFlagPkg::arithFlags_t arithFlags,
  input  logic dataEn,
  input  logic error,
  input  logic thread,
  input  logic except,
  input  logic exceptThread,
  output aluOpPkg::dataWord_t result,
  output aluFlagPkg::retData_t retData,
  output logic retEn
);

  aluOpPkg::dataWord_t resReg;
  aluOpPkg::opClass_t classReg;
  aluOpPkg::opWidth_e widthReg;
  aluFlagPkg::arithFlags_t arithFlagsReg;
  logic dataEnReg;
  logic errorReg;
  logic exceptD1;
  logic exceptThreadD1;
  logic inhibit;
  logic inhibitReg;
  logic signBit;
  logic zeroBit;
  logic setsFlags;
  logic [`ALU_FLAG_W-1:0] flagMask;

  // exception on this thread now or one cycle back
  assign inhibit = (except & (exceptThread == thread)) |
                   (exceptD1 & (exceptThreadD1 == thread));

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      resReg <= '0;
      classReg <= '0;
      dataEnReg <= 1'b0;
      errorReg <= 1'b0;
      exceptD1 <= 1'b0;
      inhibitReg <= 1'b0;
    end
    else
    begin
      resReg <= opClass.arith ? arithResult : lmResult;
      classReg <= opClass;
      dataEnReg <= dataEn;
      errorReg <= error;
      exceptD1 <= except;
      inhibitReg <= inhibit;
    end
  end

  always_ff @(posedge clk)
  begin
    widthReg <= width;
    arithFlagsReg <= arithFlags; // zero for logic ops, adder idle
    exceptThreadD1 <= exceptThread;
  end

  always_comb
  begin
    case (widthReg)
      aluOpPkg::w8:
      begin
        signBit = resReg[7];
        zeroBit = (resReg[7:0] == '0);
      end
      aluOpPkg::w16:
      begin
        signBit = resReg[15];
        zeroBit = (resReg[15:0] == '0);
      end
      aluOpPkg::w32:
      begin
        signBit = resReg[31];
        zeroBit = (resReg[31:0] == '0);
      end
      default:
      begin
        signBit = resReg[63];
        zeroBit = (resReg == '0);
      end
    endcase
  end

  assign setsFlags = classReg.writesFlags & dataEnReg & ~errorReg;
  assign flagMask = {`ALU_FLAG_W{setsFlags}};

  assign result = resReg;
  assign retData.status = errorReg ? aluFlagPkg::fault :
                          (dataEnReg ? aluFlagPkg::done : aluFlagPkg::idle);
  assign retData.setsFlags = setsFlags;
  // even parity of the low byte
  assign retData.flags = aluFlagPkg::aluFlags_t'(
    {arithFlagsReg, signBit, zeroBit, ~^resReg[7:0]} & flagMask);
  assign retEn = dataEnReg & ~inhibitReg;

  rstQuiet: assert property (@(posedge clk) rst |=> !retEn)
    else $error("retEn high in the cycle after reset");

  faultNoFlags: assert property (@(posedge clk) disable iff (rst)
    retData.status == aluFlagPkg::fault |-> !retData.setsFlags)
    else $error("flags written on a faulting op");

endmodule

// ==== aluLogicMove.sv ====
// ALU logic and move unit: bitwise ops, moves, extends, cmov and cset
`timescale 1ns/1ps
`include "alu_macros.svh"

module aluLogicMove (
  input  aluOpPkg::aluOp_t op,
  input  aluOpPkg::opClass_t opClass,
  input  aluOpPkg::dataWord_t val1,
  input  aluOpPkg::dataWord_t val2,
  input  aluFlagPkg::aluFlags_t condFlags,
  output aluOpPkg::dataWord_t lmResult
);

  aluOpPkg::dataWord_t logicVal;
  aluOpPkg::dataWord_t zextVal;
  aluOpPkg::dataWord_t sextVal;
  aluOpPkg::dataWord_t moveVal;
  logic taken;

  condEval uCond (
    .flags (condFlags),
    .cond  (op.cond),
    .taken (taken)
  );

  always_comb
  begin
    case (op.opcode)
      aluOpPkg::andOp:  logicVal = val1 & val2;
      aluOpPkg::andNot: logicVal = val1 & ~val2;
      aluOpPkg::orOp:   logicVal = val1 | val2;
      aluOpPkg::xorOp:  logicVal = val1 ^ val2;
      default:          logicVal = ~(val1 ^ val2); // xnor
    endcase
  end

  // extends fill the whole register from the low op-width bits of val2
  always_comb
  begin
    case (op.width)
      aluOpPkg::w8:
      begin
        zextVal = {56'b0, val2[7:0]};
        sextVal = {{56{val2[7]}}, val2[7:0]};
      end
      aluOpPkg::w16:
      begin
        zextVal = {48'b0, val2[15:0]};
        sextVal = {{48{val2[15]}}, val2[15:0]};
      end
      aluOpPkg::w32:
      begin
        zextVal = {32'b0, val2[31:0]};
        sextVal = {{32{val2[31]}}, val2[31:0]};
      end
      default:
      begin
        zextVal = val2;
        sextVal = val2;
      end
    endcase
  end

  always_comb
  begin
    case (op.opcode)
      aluOpPkg::zext: moveVal = zextVal;
      aluOpPkg::sext: moveVal = sextVal;
      default:        moveVal = aluOpPkg::applyWidth(op.width, val1, val2);
    endcase
  end

  always_comb
  begin
    lmResult = '0;
    if (opClass.logical)
      lmResult = aluOpPkg::applyWidth(op.width, val1, logicVal);
    else if (opClass.move)
      lmResult = moveVal;
    else if (opClass.cond && op.opcode == aluOpPkg::cmov)
      lmResult = taken ? val2 : val1; // always full width
    else if (opClass.cond)
      lmResult = {{(`ALU_DATA_W-1){1'b0}}, taken};
  end

  always_comb
  begin
    if (opClass.cond && op.opcode == aluOpPkg::cset)
    begin
      assert ((lmResult >> 1) == '0)
        else $error("cset result not 0 or 1");
    end
  end

endmodule

// ==== condEval.sv ====
// condition evaluation of a condition code against a flag word
`timescale 1ns/1ps

module condEval (
  input  aluFlagPkg::aluFlags_t flags,
  input  aluFlagPkg::condCode_e cond,
  output logic taken
);

  logic base;
  logic signedLt;

  assign signedLt = flags.s ^ flags.o;

  // first condition of each pair
  always_comb
  begin
    case (cond)
      aluFlagPkg::eq,
      aluFlagPkg::ne:
        base = flags.z;
      aluFlagPkg::neg,
      aluFlagPkg::pos:
        base = flags.s;
      aluFlagPkg::ult,
      aluFlagPkg::uge:
        base = flags.c; // c is borrow after sub
      aluFlagPkg::ule,
      aluFlagPkg::ugt:
        base = flags.c | flags.z;
      aluFlagPkg::slt,
      aluFlagPkg::sge:
        base = signedLt;
      aluFlagPkg::sle,
      aluFlagPkg::sgt:
        base = signedLt | flags.z;
      aluFlagPkg::ovf,
      aluFlagPkg::nov:
        base = flags.o;
      default:
        base = flags.p;
    endcase
  end

  assign taken = base ^ cond[0]; // odd codes invert

endmodule

// ==== aluAdder.sv ====
// ALU adder: width-aware add/subtract with carry, overflow and nibble carry
`timescale 1ns/1ps
`include "alu_macros.svh"

module aluAdder (
  input  aluOpPkg::aluOp_t op,
  input  aluOpPkg::opClass_t opClass,
  input  aluOpPkg::dataWord_t val1,
  input  aluOpPkg::dataWord_t val2,
  output aluOpPkg::dataWord_t arithResult,
  output aluFlagPkg::arithFlags_t arithFlags
);

  aluOpPkg::dataWord_t opA;
  aluOpPkg::dataWord_t opB;
  aluOpPkg::dataWord_t sum;
  aluOpPkg::dataWord_t carryIn; // carry into each bit
  logic isSub;
  logic carryTop;
  logic carryOut;
  logic carryMsb;

  // operands forced to zero when another unit owns the op
  assign isSub = opClass.arith & (op.opcode == aluOpPkg::sub);
  assign opA = opClass.arith ? val1 : '0;
  assign opB = opClass.arith ? (val2 ^ {`ALU_DATA_W{isSub}}) : '0;

  assign {carryTop, sum} = {1'b0, opA} + {1'b0, opB} + {{`ALU_DATA_W{1'b0}}, isSub};
  assign carryIn = sum ^ opA ^ opB;

  // carry out of and into the top bit at the op width
  always_comb
  begin
    case (op.width)
      aluOpPkg::w8:
      begin
        carryOut = carryIn[8];
        carryMsb = carryIn[7];
      end
      aluOpPkg::w16:
      begin
        carryOut = carryIn[16];
        carryMsb = carryIn[15];
      end
      aluOpPkg::w32:
      begin
        carryOut = carryIn[32];
        carryMsb = carryIn[31];
      end
      default:
      begin
        carryOut = carryTop;
        carryMsb = carryIn[63];
      end
    endcase
  end

  assign arithFlags.c = carryOut ^ isSub; // borrow on sub
  assign arithFlags.o = carryOut ^ carryMsb;
  assign arithFlags.a = carryIn[4] ^ isSub;

  assign arithResult = aluOpPkg::applyWidth(op.width, opA, sum);

endmodule

// ==== aluDecode.sv ====
// ALU decode: opcode to one-hot unit class and flag write enable
`timescale 1ns/1ps

module aluDecode (
  input  aluOpPkg::aluOp_t op,
  output aluOpPkg::opClass_t opClass
);

  logic legal;

  // opcodes past cset are unused
  assign legal = (op.opcode <= aluOpPkg::cset);

  always_comb
  begin
    opClass = '0;
    case (op.opcode)
      aluOpPkg::add,
      aluOpPkg::sub:
        opClass.arith = 1'b1;
      aluOpPkg::andOp,
      aluOpPkg::andNot,
      aluOpPkg::orOp,
      aluOpPkg::xorOp,
      aluOpPkg::xnorOp:
        opClass.logical = 1'b1;
      aluOpPkg::mov,
      aluOpPkg::zext,
      aluOpPkg::sext:
        opClass.move = 1'b1;
      aluOpPkg::cmov,
      aluOpPkg::cset:
        opClass.cond = 1'b1;
      default: ; // unused opcodes select nothing
    endcase
    // only adder and logic results produce flags
    opClass.writesFlags = op.setFlags & (opClass.arith | opClass.logical);
  end

  always_comb
  begin
    if (legal)
    begin
      assert ($onehot({opClass.arith, opClass.logical, opClass.move, opClass.cond}))
        else $error("decode class not one-hot for opcode %0d", op.opcode);
    end
  end

endmodule

// ==== aluOpPkg.sv ====
// operation, opcode, width and unit class types for the ALU
`include "alu_macros.svh"

package aluOpPkg;

  typedef logic [`ALU_DATA_W-1:0] dataWord_t;

  typedef enum logic [`ALU_OPC_W-1:0] {
    add, sub,
    andOp, andNot, orOp, xorOp, xnorOp,
    mov, zext, sext,
    cmov, cset
  } opcode_e;

  typedef enum logic [`ALU_OPW_W-1:0] {
    w8, w16, w32, w64
  } opWidth_e;

  typedef struct packed {
    opcode_e opcode;
    opWidth_e width;
    aluFlagPkg::condCode_e cond;
    logic setFlags;
  } aluOp_t;

  // one unit bit per op, plus flag write
  typedef struct packed {
    logic arith;
    logic logical;
    logic move;
    logic cond;
    logic writesFlags;
  } opClass_t;

  // 64 whole, 32 zero-extended, 8/16 merge into keep
  function automatic dataWord_t applyWidth(
    input opWidth_e width,
    input dataWord_t keep,
    input dataWord_t res
  );
    dataWord_t merged;
    case (width)
      w8:      merged = {keep[63:8], res[7:0]};
      w16:     merged = {keep[63:16], res[15:0]};
      w32:     merged = {32'b0, res[31:0]};
      default: merged = res;
    endcase
    return merged;
  endfunction

endpackage

// ==== aluFlagPkg.sv ====
// flag word, condition code and retire record types for the ALU
`include "alu_macros.svh"

package aluFlagPkg;

  typedef struct packed {
    logic c;
    logic o;
    logic a;
    logic s;
    logic z;
    logic p;
  } aluFlags_t;

  // adder side of the flag word
  typedef struct packed {
    logic c;
    logic o;
    logic a;
  } arithFlags_t;

  // pairs, odd code is the inverse
  typedef enum logic [`ALU_COND_W-1:0] {
    eq, ne,   // Z
    neg, pos, // S
    ult, uge, // C
    ule, ugt, // C | Z
    slt, sge, // S ^ O
    sle, sgt, // (S ^ O) | Z
    ovf, nov, // O
    par, npar // P
  } condCode_e;

  typedef enum logic [`ALU_ST_W-1:0] {
    idle  = `ALU_ST_IDLE,
    fault = `ALU_ST_FAULT,
    done  = `ALU_ST_DONE
  } retStatus_e;

  typedef struct packed {
    retStatus_e status;
    logic setsFlags;
    aluFlags_t flags;
  } retData_t;

endpackage

// ==== alu_macros.svh ====
// ALU stage widths and retire status encodings
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// operand and result width
`define ALU_DATA_W 64

// c o a s z p
`define ALU_FLAG_W 6

`define ALU_COND_W 4 // condition code, bit 0 inverts

// opcode and operation width fields
`define ALU_OPC_W 4
`define ALU_OPW_W 2

// retire status
`define ALU_ST_W 2
`define ALU_ST_IDLE 2'd0
`define ALU_ST_FAULT 2'd1
`define ALU_ST_DONE 2'd2

`endif
